// File: include/fp8la_consts.svh
/*
 * FP8 log-scale summer constants.
 * Buffer depth, item counter width and the adder's offset table cutoff.
 */

`ifndef FP8LA_CONSTS_SVH
`define FP8LA_CONSTS_SVH

// Entries held between the pair stage and the accumulator.
`define FP8LA_FIFO_DEPTH 8

// Width of the accumulated item count.
`define FP8LA_COUNT_W 8

// Magnitude difference at and above which the smaller operand is lost.
`define FP8LA_DIFF_CUTOFF 32

`endif

// File: verilog/fp8la_pkg.sv
/*
 * FP8 log-scale summer types.
 * Value and magnitude vectors, the lane pair, the result word
 * and the accumulator states.
 */

`default_nettype none

`include "fp8la_consts.svh"

package fp8la_pkg;

	typedef logic [7:0] fp8Val;                   // Sign plus log magnitude.
	typedef logic [6:0] fp8Mag;                   // Log magnitude only.
	typedef logic [`FP8LA_COUNT_W-1:0] fp8Count;

	typedef struct packed
	{
		fp8Val laneA;
		fp8Val laneB;
	} fp8Pair;

	typedef struct packed
	{
		fp8Val sum;
		fp8Count count;
	} fp8Result;

	typedef enum logic [1:0]
	{
		AccIdle,
		AccRun,
		AccDone
	} accumState;

endpackage

`default_nettype wire

// File: verilog/Fp8LaAdd.sv
/*
 * Low accuracy FP8 log-scale adder.
 * The larger magnitude is kept and a table offset, picked by the
 * magnitude difference and whether the signs differ, is added to it.
 * Results past the top saturate, results below zero flush to zero.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fp8la_consts.svh"

module Fp8LaAdd
(
	input  fp8la_pkg::fp8Val valA,
	input  fp8la_pkg::fp8Val valB,
	output fp8la_pkg::fp8Val valC
);

	import fp8la_pkg::*;

	fp8Mag magX;                 // Larger magnitude.
	fp8Mag magY;                 // Smaller magnitude.
	fp8Mag diff;
	logic signX;
	logic isSub;
	logic [5:0] tableIdx;
	logic [7:0] offset;          // Two's complement step in log units.
	logic [8:0] sumWide;

	always_comb
	begin
		isSub = valA[7] ^ valB[7];

		if (valA[6:0] > valB[6:0])
		begin
			magX  = valA[6:0];
			magY  = valB[6:0];
			signX = valA[7];
		end
		else
		begin
			magX  = valB[6:0];
			magY  = valA[6:0];
			signX = valB[7];
		end

		diff     = magX - magY;  // Never negative.
		tableIdx = {isSub, diff[4:0]};
		offset   = 8'h00;

		case (tableIdx)
			// Same sign, the sum grows by at most one doubling.
			6'h00, 6'h01:
				offset = 8'h08;
			6'h02, 6'h03:
				offset = 8'h07;
			6'h04, 6'h05:
				offset = 8'h06;
			6'h06, 6'h07:
				offset = 8'h05;
			6'h08, 6'h09, 6'h0A, 6'h0B:
				offset = 8'h04;
			6'h0C, 6'h0D, 6'h0E, 6'h0F:
				offset = 8'h03;
			6'h10, 6'h11, 6'h12, 6'h13, 6'h14, 6'h15, 6'h16, 6'h17:
				offset = 8'h02;
			6'h18, 6'h19, 6'h1A, 6'h1B, 6'h1C, 6'h1D, 6'h1E, 6'h1F:
				offset = 8'h01;
			// Opposite signs, equal magnitudes cancel completely.
			6'h20:
				offset = 8'h80;
			6'h21:
				offset = 8'hE3;
			6'h22:
				offset = 8'hEA;
			6'h23:
				offset = 8'hEE;
			6'h24:
				offset = 8'hF1;
			6'h25:
				offset = 8'hF3;
			6'h26:
				offset = 8'hF5;
			6'h27:
				offset = 8'hF7;
			6'h28:
				offset = 8'hF8;
			6'h29:
				offset = 8'hF9;
			6'h2A, 6'h2B:
				offset = 8'hFA;
			6'h2C, 6'h2D:
				offset = 8'hFB;
			6'h2E, 6'h2F, 6'h30:
				offset = 8'hFC;
			6'h31, 6'h32, 6'h33, 6'h34:
				offset = 8'hFD;
			6'h35, 6'h36, 6'h37, 6'h38, 6'h39, 6'h3A:
				offset = 8'hFE;
			default:
				offset = 8'hFF;  // 0x3B to 0x3F.
		endcase

		if (diff >= fp8Mag'(`FP8LA_DIFF_CUTOFF))
			offset = 8'h00;      // Smaller operand is below resolution.

		sumWide = {2'b00, magX} + {offset[7], offset};

		case (sumWide[8:7])
			2'b00:
				valC = {signX, sumWide[6:0]};
			2'b01:
				valC = {signX, 7'h7F};  // Saturate.
			default:
				valC = 8'h00;           // Went negative.
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/Fp8PairStage.sv
/*
 * FP8 pair stage.
 * Adds the two input lanes and registers the sum with its strobe,
 * one cycle after the input strobe.
 */

`timescale 1ns/1ps
`default_nettype none

module Fp8PairStage
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 inStrobe,
	input  fp8la_pkg::fp8Pair    inPair,
	output logic                 pairStrobe,
	output fp8la_pkg::fp8Val     pairSum
);

	import fp8la_pkg::*;

	fp8Val laneSum;

	Fp8LaAdd addLanes
	(
		.valA (inPair.laneA),
		.valB (inPair.laneB),
		.valC (laneSum)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
			pairStrobe <= 1'b0;
		else
			pairStrobe <= inStrobe;
	end

	always_ff @(posedge clock)
	begin
		if (inStrobe)
			pairSum <= laneSum;   // Held until the next strobe.
	end

	// The strobe and its sum leave together, one cycle late.
	assert property (@(posedge clock) disable iff (reset)
		inStrobe |=> pairStrobe && (pairSum == $past(laneSum)));

	assert property (@(posedge clock) disable iff (reset)
		!inStrobe |=> !pairStrobe);

endmodule

`default_nettype wire

// File: verilog/Fp8Fifo.sv
/*
 * FP8 value FIFO.
 * Circular buffer with an occupancy counter. A push into a full
 * buffer without a pop is dropped and latches overrun until reset.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fp8la_consts.svh"

module Fp8Fifo
(
	input  logic             clock,
	input  logic             reset,
	input  logic             push,
	input  fp8la_pkg::fp8Val pushData,
	input  logic             pop,
	output fp8la_pkg::fp8Val popData,
	output logic             empty,
	output logic             overrun
);

	import fp8la_pkg::*;

	localparam int Depth = `FP8LA_FIFO_DEPTH;
	localparam int PtrW  = $clog2(Depth);
	localparam int CntW  = $clog2(Depth + 1);

	fp8Val mem [Depth];
	logic [PtrW-1:0] writePtr;
	logic [PtrW-1:0] readPtr;
	logic [CntW-1:0] occupancy;
	logic full;
	logic doPush;
	logic doPop;

	assign full    = (occupancy == CntW'(Depth));
	assign empty   = (occupancy == '0);
	assign doPop   = pop && !empty;
	assign doPush  = push && (!full || pop);  // Pop frees a slot this cycle.
	assign popData = mem[readPtr];

	always_ff @(posedge clock)
	begin
		if (doPush)
			mem[writePtr] <= pushData;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writePtr  <= '0;
			readPtr   <= '0;
			occupancy <= '0;
			overrun   <= 1'b0;
		end
		else
		begin
			if (doPush)
				writePtr <= (writePtr == PtrW'(Depth - 1)) ? '0 : writePtr + 1'b1;
			if (doPop)
				readPtr <= (readPtr == PtrW'(Depth - 1)) ? '0 : readPtr + 1'b1;
			occupancy <= occupancy + CntW'(doPush) - CntW'(doPop);
			if (push && full && !pop)
				overrun <= 1'b1;  // Sticky.
		end
	end

	// The consumer must look at empty before popping.
	assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty);

	assert property (@(posedge clock) disable iff (reset)
		occupancy <= CntW'(Depth));

endmodule

`default_nettype wire

// File: verilog/Fp8LaAccum.sv
/*
 * FP8 log-scale accumulator.
 * Pops buffered values while not held and folds them into a running
 * sum. After a flush it waits for the buffer to drain, then presents
 * the sum and item count with a one-cycle valid pulse and clears.
 */

`timescale 1ns/1ps
`default_nettype none

module Fp8LaAccum
(
	input  logic                clock,
	input  logic                reset,
	input  fp8la_pkg::fp8Val    popData,
	input  logic                empty,
	input  logic                hold,
	input  logic                flush,
	output logic                pop,
	output fp8la_pkg::fp8Result result,
	output logic                resultValid
);

	import fp8la_pkg::*;

	accumState state;
	fp8Val sumReg;
	fp8Val sumNext;
	fp8Count countReg;

	Fp8LaAdd addRunning
	(
		.valA (sumReg),
		.valB (popData),
		.valC (sumNext)
	);

	// No popping while the result is on display.
	assign pop         = !hold && !empty && (state != AccDone);
	assign resultValid = (state == AccDone);
	assign result      = '{sum: sumReg, count: countReg};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state    <= AccIdle;
			sumReg   <= 8'h00;
			countReg <= '0;
		end
		else
		begin
			if (state == AccDone)
			begin
				sumReg   <= 8'h00;
				countReg <= '0;
			end
			else if (pop)
			begin
				sumReg   <= sumNext;
				countReg <= countReg + 1'b1;
			end

			case (state)
				AccIdle:
					if (flush)
						state <= AccRun;         // Armed.
				AccRun:
					if (empty && !hold)
						state <= AccDone;        // Drained.
				AccDone:
					state <= flush ? AccRun : AccIdle;
				default:
					state <= AccIdle;
			endcase
		end
	end

	// Each drain ends in exactly one result cycle.
	assert property (@(posedge clock) disable iff (reset)
		resultValid |=> !resultValid);

endmodule

`default_nettype wire

// File: verilog/Fp8LaSumTop.sv
/*
 * FP8 log-scale summer.
 * Pair stage feeds a FIFO that the accumulator drains into
 * a running sum, reported on flush.
 */

`timescale 1ns/1ps
`default_nettype none

module Fp8LaSumTop
(
	input  logic                clock,
	input  logic                reset,
	input  logic                inStrobe,
	input  fp8la_pkg::fp8Pair   inPair,
	input  logic                flush,
	input  logic                hold,
	output fp8la_pkg::fp8Result result,
	output logic                resultValid,
	output logic                overrun
);

	import fp8la_pkg::*;

	fp8Val pairSum;
	logic pairStrobe;
	fp8Val popData;
	logic pop;
	logic empty;

	Fp8PairStage pairStage
	(
		.clock      (clock),
		.reset      (reset),
		.inStrobe   (inStrobe),
		.inPair     (inPair),
		.pairStrobe (pairStrobe),
		.pairSum    (pairSum)
	);

	Fp8Fifo sumFifo
	(
		.clock    (clock),
		.reset    (reset),
		.push     (pairStrobe),
		.pushData (pairSum),
		.pop      (pop),
		.popData  (popData),
		.empty    (empty),
		.overrun  (overrun)
	);

	Fp8LaAccum accum
	(
		.clock       (clock),
		.reset       (reset),
		.popData     (popData),
		.empty       (empty),
		.hold        (hold),
		.flush       (flush),
		.pop         (pop),
		.result      (result),
		.resultValid (resultValid)
	);

endmodule

`default_nettype wire

// File: test/tb_Fp8LaSumTop.sv
/*
 * Testbench for the FP8 log-scale summer.
 * Drives lane pairs, hold and flush, and predicts each result from
 * the adder rules. Concurrent assertions check the result port,
 * the quiet start and the sticky overrun flag.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fp8la_consts.svh"

module tb_Fp8LaSumTop;

	import fp8la_pkg::*;

	localparam int MaxCycles = 400;  // Well above the roughly 90 cycles needed.

	logic clock;
	logic reset;
	logic inStrobe;
	fp8Pair inPair;
	logic flush;
	logic hold;
	fp8Result result;
	logic resultValid;
	logic overrun;

	fp8Val expSum;
	fp8Count expCount;
	logic flushSeen;
	logic overfillDriven;
	logic expOverrun;
	integer seed;
	int cycleCount;

	Fp8LaSumTop UUT
	(
		.clock       (clock),
		.reset       (reset),
		.inStrobe    (inStrobe),
		.inPair      (inPair),
		.flush       (flush),
		.hold        (hold),
		.result      (result),
		.resultValid (resultValid),
		.overrun     (overrun)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;
	end

	task automatic reportFail();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	// Bit 8 set means the operands hit a case the rules leave open.
	function automatic logic [8:0] ruleSum(input fp8Val a, input fp8Val b);
		fp8Mag x;
		fp8Mag y;
		logic sx;
		int d;
		int m;
		if (a[6:0] >= b[6:0])
		begin
			x  = a[6:0];
			y  = b[6:0];
			sx = a[7];
		end
		else
		begin
			x  = b[6:0];
			y  = a[6:0];
			sx = b[7];
		end
		d = int'(x) - int'(y);
		if (d >= `FP8LA_DIFF_CUTOFF)
			return {1'b0, sx, x};            // Smaller one is lost.
		if (d == 0 && a[7] != b[7])
			return 9'h000;                   // Full cancellation.
		if (d == 0)
		begin
			m = int'(x) + 8;
			if (m > 127)
				return {1'b0, sx, 7'h7F};    // Saturate.
			return {1'b0, sx, 7'(m)};
		end
		return 9'h100;
	endfunction

	task automatic foldPair(input fp8Pair p);
		logic [8:0] pairRes;
		logic [8:0] accRes;
		pairRes = ruleSum(p.laneA, p.laneB);
		accRes  = ruleSum(expSum, pairRes[7:0]);
		if (pairRes[8] || accRes[8])
		begin
			$display("Stimulus reached an adder case that the rules give no result for.");
			reportFail();
		end
		expSum   = accRes[7:0];
		expCount = expCount + 1'b1;
	endtask

	task automatic applyReset();
		reset          = 1'b1;
		expSum         = 8'h00;
		expCount       = '0;
		flushSeen      = 1'b0;
		overfillDriven = 1'b0;
		expOverrun     = 1'b0;
		repeat (4) @(negedge clock);
		reset = 1'b0;
	endtask

	// Magnitude of 32 or more, random sign.
	task automatic pickLaneA(output fp8Val v);
		integer rnd;
		rnd = $random(seed);
		v   = {rnd[16], 7'd32 + 7'((rnd & 32'h7FFF) % 96)};
	endtask

	task automatic sendPair(input fp8Val a, input fp8Val b, input logic track);
		inStrobe = 1'b1;
		inPair   = '{laneA: a, laneB: b};
		if (track)
			foldPair(inPair);
		@(negedge clock);
		inStrobe = 1'b0;
	endtask

	task automatic flushAndCheck();
		@(negedge clock);
		flush     = 1'b1;
		flushSeen = 1'b1;
		@(negedge clock);
		flush = 1'b0;
		while (!resultValid)
			@(negedge clock);
		@(negedge clock);      // Let the checks sample the result first.
		expSum   = 8'h00;
		expCount = '0;
	endtask

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MaxCycles)
		begin
			$display("Timeout: no finish within %0d clock cycles.", MaxCycles);
			reportFail();
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		resultValid |-> result.sum == expSum)
	else
	begin
		$display("Error: time %0t, result.sum expected 0x%02h, actual 0x%02h",
			$time, $sampled(expSum), $sampled(result.sum));
		reportFail();
	end

	assert property (@(posedge clock) disable iff (reset)
		resultValid |-> result.count == expCount)
	else
	begin
		$display("Error: time %0t, result.count expected %0d, actual %0d",
			$time, $sampled(expCount), $sampled(result.count));
		reportFail();
	end

	// Quiet until the first flush.
	assert property (@(posedge clock) disable iff (reset)
		!flushSeen |-> !resultValid)
	else
	begin
		$display("Error: time %0t, resultValid expected 0, actual 1", $time);
		reportFail();
	end

	assert property (@(posedge clock) disable iff (reset)
		!overfillDriven |-> !overrun)
	else
	begin
		$display("Error: time %0t, overrun expected 0, actual 1", $time);
		reportFail();
	end

	assert property (@(posedge clock) disable iff (reset)
		expOverrun |-> overrun)
	else
	begin
		$display("Error: time %0t, overrun expected 1, actual 0", $time);
		reportFail();
	end

	assert property (@(posedge clock) disable iff (reset)
		overrun |=> overrun)
	else
	begin
		$display("Error: time %0t, overrun expected 1, actual 0", $time);
		reportFail();
	end

	initial
	begin
		fp8Val a;
		reset          = 1'b1;
		inStrobe       = 1'b0;
		inPair         = '0;
		flush          = 1'b0;
		hold           = 1'b0;
		flushSeen      = 1'b0;
		overfillDriven = 1'b0;
		expOverrun     = 1'b0;
		expSum         = 8'h00;
		expCount       = '0;
		cycleCount     = 0;
		seed           = 50;

		applyReset();
		repeat (3) @(negedge clock);

		// Single pairs, laneB adds nothing.
		for (int i = 0; i < 4; i++)
		begin
			pickLaneA(a);
			sendPair(a, 8'h00, 1'b1);
			flushAndCheck();
		end

		// Cancellation, then saturation.
		pickLaneA(a);
		sendPair(a, a ^ 8'h80, 1'b1);
		flushAndCheck();
		sendPair(8'h7F, 8'h7F, 1'b1);
		flushAndCheck();

		// Five buffered pairs folded in order.
		hold = 1'b1;
		sendPair(8'h20, 8'h00, 1'b1);
		sendPair(8'h20, 8'h00, 1'b1);
		sendPair(8'h28, 8'h00, 1'b1);
		sendPair(8'h30, 8'h00, 1'b1);
		sendPair(8'hFF, 8'h00, 1'b1);
		repeat (2) @(negedge clock);
		hold = 1'b0;
		flushAndCheck();

		// Overfill the FIFO while the accumulator is held.
		hold           = 1'b1;
		overfillDriven = 1'b1;
		for (int i = 0; i < `FP8LA_FIFO_DEPTH + 2; i++)
		begin
			pickLaneA(a);
			sendPair(a, 8'h00, 1'b0);
		end
		repeat (2) @(negedge clock);
		expOverrun = 1'b1;
		repeat (5) @(negedge clock);

		applyReset();
		repeat (3) @(negedge clock);
		hold = 1'b0;
		repeat (3) @(negedge clock);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
verilog/fp8la_pkg.sv
verilog/Fp8LaAdd.sv
verilog/Fp8PairStage.sv
verilog/Fp8Fifo.sv
verilog/Fp8LaAccum.sv
verilog/Fp8LaSumTop.sv
test/tb_Fp8LaSumTop.sv

// File: Bender.yml
package:
  name: fp8la_sum

sources:
  - include_dirs:
      - include
    files:
      - verilog/fp8la_pkg.sv
      - verilog/Fp8LaAdd.sv
      - verilog/Fp8PairStage.sv
      - verilog/Fp8Fifo.sv
      - verilog/Fp8LaAccum.sv
      - verilog/Fp8LaSumTop.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/tb_Fp8LaSumTop.sv
